//--- tb/issue_core_tests.txt
// unit(0 alu,1 mul) inst rs1_rdy rs1_data rs1_tag rs2_rdy rs2_data rs2_tag dest expected
// operands with rdy 0 wait on their tag, data there is junk
0 002081B3 1 7FFFFFFF 00 1 00000001 00 01 80000000 // add
0 402081B3 1 00000005 00 1 00000007 00 02 FFFFFFFE // sub
1 022081B3 1 FFFFFFFF 00 1 FFFFFFFF 00 14 00000001 // mul
0 002091B3 1 00000001 00 1 00000025 00 03 00000020 // sll
1 022091B3 1 80000000 00 1 80000000 00 15 40000000 // mulh
0 0020A1B3 1 80000000 00 1 00000001 00 04 00000001 // slt
1 0220A1B3 1 FFFFFFFF 00 1 FFFFFFFF 00 16 FFFFFFFF // mulhsu
1 0220B1B3 1 FFFFFFFF 00 1 FFFFFFFF 00 17 FFFFFFFE // mulhu
1 022081B3 1 80000000 00 1 FFFFFFFF 00 18 80000000 // mul
0 0020B1B3 1 80000000 00 1 00000001 00 05 00000000 // sltu
0 0020C1B3 1 FF00FF00 00 1 0F0F0F0F 00 06 F00FF00F // xor
0 0020D1B3 1 F0000000 00 1 00000004 00 07 0F000000 // srl
0 4020D1B3 1 F0000000 00 1 00000004 00 08 FF000000 // sra
0 0020E1B3 1 0000F0F0 00 1 00000F0F 00 09 0000FFFF // or
0 0020F1B3 1 12345678 00 1 0F0F0F0F 00 0A 02040608 // and
0 FFB08193 1 00000010 00 1 00000000 00 0B 0000000B // addi -5
0 FFF0A193 1 FFFFFFFE 00 1 00000000 00 0C 00000001 // slti -1
0 FFF0B193 1 00000005 00 1 00000000 00 0D 00000001 // sltiu -1
0 0F00C193 1 12345678 00 1 00000000 00 0E 12345688 // xori
0 7FF0E193 1 80000000 00 1 00000000 00 0F 800007FF // ori
0 0FF0F193 1 DEADBEEF 00 1 00000000 00 10 000000EF // andi
0 00409193 1 0000ABCD 00 1 00000000 00 11 000ABCD0 // slli 4
0 0080D193 1 80000000 00 1 00000000 00 12 00800000 // srli 8
0 4080D193 1 80000000 00 1 00000000 00 13 FF800000 // srai 8
0 002081B3 0 DEADDEAD 1A 1 00000003 00 19 0000002D // add waiting on tag 1a
1 022081B3 1 00000006 00 1 00000007 00 1A 0000002A // mul producer
1 022081B3 1 00000003 00 0 DEADDEAD 1C 1B 0000000C // mul waiting on tag 1c
0 0020C1B3 1 00000005 00 1 00000001 00 1C 00000004 // xor producer

//--- issue_core.f
hdl/rv32i_types_pkg.sv
hdl/ooo_types_pkg.sv
hdl/reservation_station.sv
hdl/int_alu.sv
hdl/mul_unit.sv
hdl/cdb_arbiter.sv
hdl/issue_core.sv
tb/tb_issue_core.sv

//--- Bender.yml
package:
  name: issue_core

sources:
  - files:
      - hdl/rv32i_types_pkg.sv
      - hdl/ooo_types_pkg.sv
      - hdl/reservation_station.sv
      - hdl/int_alu.sv
      - hdl/mul_unit.sv
      - hdl/cdb_arbiter.sv
      - hdl/issue_core.sv
  - target: test
    files:
      - tb/tb_issue_core.sv

//--- tb/tb_issue_core.sv
module tb_issue_core;
    import ooo_types_pkg::*;

    localparam int ROB_IDX_WIDTH = 5;
    localparam int MUL_STAGES    = 3;
    localparam int NUM_TAGS      = 2 ** ROB_IDX_WIDTH;
    // ten hex fields per line of the data file
    localparam int NUM_TESTS     = 28;
    localparam int FIELDS        = 10;
    localparam int WAIT_LIMIT    = 200;
    localparam int DRAIN_LIMIT   = 400;

    logic                     clk;
    logic                     rst;
    logic                     dispatch_valid;
    exec_unit_e               dispatch_unit;
    logic [31:0]              dispatch_inst;
    logic [ROB_IDX_WIDTH-1:0] dispatch_rob_idx;
    logic                     rs1_ready;
    logic [31:0]              rs1_data;
    logic [ROB_IDX_WIDTH-1:0] rs1_rob_idx;
    logic                     rs2_ready;
    logic [31:0]              rs2_data;
    logic [ROB_IDX_WIDTH-1:0] rs2_rob_idx;
    logic                     alu_available;
    logic                     mul_available;
    logic                     cdb_valid;
    logic [ROB_IDX_WIDTH-1:0] cdb_rob_idx;
    logic [31:0]              cdb_data;

    logic [31:0]              vec [NUM_TESTS*FIELDS];
    // scoreboard, indexed by rob tag
    logic [31:0]              expected [NUM_TAGS];
    logic                     pending [NUM_TAGS];
    logic                     seen [NUM_TAGS];
    logic                     is_mul [NUM_TAGS];
    logic                     dep_valid [NUM_TAGS][2];
    logic [ROB_IDX_WIDTH-1:0] dep_tag [NUM_TAGS][2];
    // multiplies leave in dispatch order
    logic [ROB_IDX_WIDTH-1:0] mul_order [$];
    int                       errors;
    int                       checks;
    int                       broadcasts;
    int                       gap;
    bit                       timed_out;
    integer                   seed;

    issue_core #(
        .ROB_IDX_WIDTH(ROB_IDX_WIDTH),
        .MUL_STAGES(MUL_STAGES)
    ) DUT (
        .clk(clk),
        .rst(rst),
        .dispatch_valid(dispatch_valid),
        .dispatch_unit(dispatch_unit),
        .dispatch_inst(dispatch_inst),
        .dispatch_rob_idx(dispatch_rob_idx),
        .rs1_ready(rs1_ready),
        .rs1_data(rs1_data),
        .rs1_rob_idx(rs1_rob_idx),
        .rs2_ready(rs2_ready),
        .rs2_data(rs2_data),
        .rs2_rob_idx(rs2_rob_idx),
        .alu_available(alu_available),
        .mul_available(mul_available),
        .cdb_valid(cdb_valid),
        .cdb_rob_idx(cdb_rob_idx),
        .cdb_data(cdb_data)
    );

    always #2 clk = ~clk;

    function automatic logic station_free(input exec_unit_e unit);
        return (unit == unit_alu) ? alu_available : mul_available;
    endfunction

    function automatic logic any_pending();
        for (int t = 0; t < NUM_TAGS; t++) begin
            if (pending[t]) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // one cdb beat against the scoreboard
    task automatic check_broadcast(input logic [ROB_IDX_WIDTH-1:0] tag, input logic [31:0] data);
        broadcasts++;
        checks++;
        assert (pending[tag] === 1'b1) else begin
            errors++;
            $display("unexpected or repeated broadcast of tag %0d at time %0t", tag, $time);
        end
        if (pending[tag] === 1'b1) begin
            checks++;
            assert (data === expected[tag]) else begin
                errors++;
                $display("[FAIL] t=%0t cdb_data (tag %0d): expected %h, got %h",
                         $time, tag, expected[tag], data);
            end
            // consumer only after its producers
            for (int k = 0; k < 2; k++) begin
                if (dep_valid[tag][k]) begin
                    checks++;
                    assert (seen[dep_tag[tag][k]] === 1'b1) else begin
                        errors++;
                        $display("tag %0d was broadcast before its producer tag %0d",
                                 tag, dep_tag[tag][k]);
                    end
                end
            end
            if (is_mul[tag]) begin
                checks++;
                assert (mul_order.size() > 0 && mul_order[0] == tag) else begin
                    errors++;
                    $display("multiply tag %0d finished out of dispatch order", tag);
                end
                if (mul_order.size() > 0) begin
                    void'(mul_order.pop_front());
                end
            end
            pending[tag] = 1'b0;
            seen[tag]    = 1'b1;
        end
    endtask

    // cdb sampled mid-cycle, well away from the rising edge
    always @(negedge clk) begin
        if (!rst && cdb_valid === 1'b1) begin
            check_broadcast(cdb_rob_idx, cdb_data);
        end
    end

    // idle state right after reset
    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            checks += 3;
            assert (alu_available === 1'b1) else begin
                errors++;
                $display("[FAIL] t=%0t alu_available: expected 1, got %b", $time, alu_available);
            end
            assert (mul_available === 1'b1) else begin
                errors++;
                $display("[FAIL] t=%0t mul_available: expected 1, got %b", $time, mul_available);
            end
            assert (cdb_valid === 1'b0) else begin
                errors++;
                $display("[FAIL] t=%0t cdb_valid: expected 0, got %b", $time, cdb_valid);
            end
            @(negedge clk);
        end
    endtask

    // called at a falling edge
    task automatic dispatch_line(input int n);
        int                       base;
        int                       waited;
        exec_unit_e               unit;
        logic [ROB_IDX_WIDTH-1:0] dest;
        base   = n * FIELDS;
        unit   = exec_unit_e'(vec[base][0]);
        dest   = vec[base+8][ROB_IDX_WIDTH-1:0];
        waited = 0;
        while (station_free(unit) !== 1'b1 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (station_free(unit) !== 1'b1) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: station for test line %0d never became available", n);
        end else begin
            expected[dest] = vec[base+9];
            pending[dest]  = 1'b1;
            is_mul[dest]   = (unit == unit_mul);
            // operand not ready means it waits on that tag
            for (int k = 0; k < 2; k++) begin
                dep_valid[dest][k] = (vec[base+2+3*k][0] == 1'b0);
                dep_tag[dest][k]   = vec[base+4+3*k][ROB_IDX_WIDTH-1:0];
            end
            if (unit == unit_mul) begin
                mul_order.push_back(dest);
            end
            dispatch_valid   = 1'b1;
            dispatch_unit    = unit;
            dispatch_inst    = vec[base+1];
            rs1_ready        = vec[base+2][0];
            rs1_data         = vec[base+3];
            rs1_rob_idx      = vec[base+4][ROB_IDX_WIDTH-1:0];
            rs2_ready        = vec[base+5][0];
            rs2_data         = vec[base+6];
            rs2_rob_idx      = vec[base+7][ROB_IDX_WIDTH-1:0];
            dispatch_rob_idx = dest;
            @(negedge clk);
            dispatch_valid = 1'b0;
        end
    endtask

    // every dispatched tag has to show up
    task automatic drain_results();
        int waited;
        waited = 0;
        while (any_pending() && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (any_pending()) begin
            errors++;
            timed_out = 1'b1;
            for (int t = 0; t < NUM_TAGS; t++) begin
                if (pending[t]) begin
                    $display("timeout: tag %0d never appeared on the CDB", t);
                end
            end
        end
    endtask

    initial begin
        clk              = 1'b0;
        rst              = 1'b1;
        dispatch_valid   = 1'b0;
        dispatch_unit    = unit_alu;
        dispatch_inst    = '0;
        dispatch_rob_idx = '0;
        rs1_ready        = 1'b0;
        rs1_data         = '0;
        rs1_rob_idx      = '0;
        rs2_ready        = 1'b0;
        rs2_data         = '0;
        rs2_rob_idx      = '0;
        errors           = 0;
        checks           = 0;
        broadcasts       = 0;
        timed_out        = 1'b0;
        seed             = 33526;
        for (int t = 0; t < NUM_TAGS; t++) begin
            pending[t]      = 1'b0;
            seen[t]         = 1'b0;
            is_mul[t]       = 1'b0;
            dep_valid[t][0] = 1'b0;
            dep_valid[t][1] = 1'b0;
        end
        $readmemh("tb/issue_core_tests.txt", vec);

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_idle(4);

        // random idle gap before each line
        for (int n = 0; n < NUM_TESTS && !timed_out; n++) begin
            gap = $unsigned($random(seed)) % 4;
            // alu line one cycle behind a multiply meets it on the bus
            if (n > 0 && vec[(n-1)*FIELDS][0] == 1'b1 && vec[n*FIELDS][0] == 1'b0) begin
                gap = 1;
            end
            repeat (gap) @(negedge clk);
            dispatch_line(n);
        end
        if (!timed_out) begin
            drain_results();
        end
        // quiet tail, catches a late duplicate
        repeat (8) @(negedge clk);

        $display("checks %0d, broadcasts %0d, errors %0d", checks, broadcasts, errors);
        if (errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- hdl/issue_core.sv
module issue_core
    import ooo_types_pkg::*;
#(
    parameter int ROB_IDX_WIDTH = 5,
    parameter int MUL_STAGES    = 3
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dispatch_valid,
    input  exec_unit_e               dispatch_unit,
    input  logic [31:0]              dispatch_inst,
    input  logic [ROB_IDX_WIDTH-1:0] dispatch_rob_idx,
    input  logic                     rs1_ready,
    input  logic [31:0]              rs1_data,
    input  logic [ROB_IDX_WIDTH-1:0] rs1_rob_idx,
    input  logic                     rs2_ready,
    input  logic [31:0]              rs2_data,
    input  logic [ROB_IDX_WIDTH-1:0] rs2_rob_idx,
    output logic                     alu_available,
    output logic                     mul_available,
    output logic                     cdb_valid,
    output logic [ROB_IDX_WIDTH-1:0] cdb_rob_idx,
    output logic [31:0]              cdb_data
);

    logic                     alu_dispatch;
    logic                     mul_dispatch;
    // station to alu
    logic                     alu_issue_valid;
    logic [31:0]              alu_issue_inst;
    logic [31:0]              alu_issue_src1;
    logic [31:0]              alu_issue_src2;
    logic [ROB_IDX_WIDTH-1:0] alu_issue_rob_idx;
    // station to multiplier
    logic                     mul_issue_valid;
    logic [31:0]              mul_issue_inst;
    logic [31:0]              mul_issue_src1;
    logic [31:0]              mul_issue_src2;
    logic [ROB_IDX_WIDTH-1:0] mul_issue_rob_idx;
    // units to arbiter
    logic                     alu_done;
    logic [ROB_IDX_WIDTH-1:0] alu_rob_idx;
    logic [31:0]              alu_result;
    logic                     alu_busy;
    logic                     alu_grant;
    logic                     mul_done;
    logic [ROB_IDX_WIDTH-1:0] mul_rob_idx;
    logic [31:0]              mul_result;

    // steer the strobe to one station
    assign alu_dispatch = dispatch_valid && (dispatch_unit == unit_alu);
    assign mul_dispatch = dispatch_valid && (dispatch_unit == unit_mul);

    // alu station held off while a result waits for the bus
    reservation_station #(.ROB_IDX_WIDTH(ROB_IDX_WIDTH)) alu_rs (
        .clk, .rst,
        .dispatch_valid(alu_dispatch), .dispatch_inst, .dispatch_rob_idx,
        .rs1_ready, .rs1_data, .rs1_rob_idx,
        .rs2_ready, .rs2_data, .rs2_rob_idx,
        .cdb_valid, .cdb_rob_idx, .cdb_data,
        .issue_enable(!alu_busy), .available(alu_available),
        .issue_valid(alu_issue_valid), .issue_inst(alu_issue_inst),
        .issue_src1(alu_issue_src1), .issue_src2(alu_issue_src2),
        .issue_rob_idx(alu_issue_rob_idx)
    );

    // multiplier never stalls, so always enabled
    reservation_station #(.ROB_IDX_WIDTH(ROB_IDX_WIDTH)) mul_rs (
        .clk, .rst,
        .dispatch_valid(mul_dispatch), .dispatch_inst, .dispatch_rob_idx,
        .rs1_ready, .rs1_data, .rs1_rob_idx,
        .rs2_ready, .rs2_data, .rs2_rob_idx,
        .cdb_valid, .cdb_rob_idx, .cdb_data,
        .issue_enable(1'b1), .available(mul_available),
        .issue_valid(mul_issue_valid), .issue_inst(mul_issue_inst),
        .issue_src1(mul_issue_src1), .issue_src2(mul_issue_src2),
        .issue_rob_idx(mul_issue_rob_idx)
    );

    int_alu #(.ROB_IDX_WIDTH(ROB_IDX_WIDTH)) u_int_alu (
        .clk, .rst,
        .issue_valid(alu_issue_valid), .issue_inst(alu_issue_inst),
        .issue_src1(alu_issue_src1), .issue_src2(alu_issue_src2),
        .issue_rob_idx(alu_issue_rob_idx), .alu_grant,
        .alu_done, .alu_rob_idx, .alu_result, .alu_busy
    );

    mul_unit #(.ROB_IDX_WIDTH(ROB_IDX_WIDTH), .MUL_STAGES(MUL_STAGES)) u_mul_unit (
        .clk, .rst,
        .issue_valid(mul_issue_valid), .issue_inst(mul_issue_inst),
        .issue_src1(mul_issue_src1), .issue_src2(mul_issue_src2),
        .issue_rob_idx(mul_issue_rob_idx),
        .mul_done, .mul_rob_idx, .mul_result
    );

    cdb_arbiter #(.ROB_IDX_WIDTH(ROB_IDX_WIDTH)) u_cdb_arbiter (
        .alu_done, .alu_rob_idx, .alu_result,
        .mul_done, .mul_rob_idx, .mul_result,
        .alu_grant, .cdb_valid, .cdb_rob_idx, .cdb_data
    );

    // mul station issues at most every other cycle
    // so a result losing to a multiply goes out on the next cycle
    a_alu_wait: assert property (@(posedge clk) disable iff (rst)
        (alu_done && !alu_grant) |=> alu_grant)
        else $error("ALU result waited more than one cycle for the CDB");

endmodule

//--- hdl/cdb_arbiter.sv
module cdb_arbiter #(
    parameter int ROB_IDX_WIDTH = 5
) (
    // alu side, held until granted
    input  logic                     alu_done,
    input  logic [ROB_IDX_WIDTH-1:0] alu_rob_idx,
    input  logic [31:0]              alu_result,
    // multiplier side, cannot wait
    input  logic                     mul_done,
    input  logic [ROB_IDX_WIDTH-1:0] mul_rob_idx,
    input  logic [31:0]              mul_result,
    output logic                     alu_grant,
    output logic                     cdb_valid,
    output logic [ROB_IDX_WIDTH-1:0] cdb_rob_idx,
    output logic [31:0]              cdb_data
);

    // fixed priority, multiply first
    assign alu_grant   = alu_done && !mul_done;
    assign cdb_valid   = mul_done || alu_done;
    assign cdb_rob_idx = mul_done ? mul_rob_idx : alu_rob_idx;
    assign cdb_data    = mul_done ? mul_result : alu_result;

endmodule

//--- hdl/mul_unit.sv
module mul_unit
    import rv32i_types_pkg::*;
#(
    parameter int ROB_IDX_WIDTH = 5,
    parameter int MUL_STAGES    = 3
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_valid,
    input  logic [31:0]              issue_inst,
    input  logic [31:0]              issue_src1,
    input  logic [31:0]              issue_src2,
    input  logic [ROB_IDX_WIDTH-1:0] issue_rob_idx,
    output logic                     mul_done,
    output logic [ROB_IDX_WIDTH-1:0] mul_rob_idx,
    output logic [31:0]              mul_result
);

    inst_word_t               inst;
    logic                     a_signed;
    logic                     b_signed;
    logic signed [32:0]       a_ext;
    logic signed [32:0]       b_ext;
    logic signed [63:0]       product;
    logic [31:0]              result;
    logic [MUL_STAGES-1:0]    valid_pipe;
    logic [ROB_IDX_WIDTH-1:0] tag_pipe [MUL_STAGES];
    logic [31:0]              data_pipe [MUL_STAGES];

    assign inst = issue_inst;
    // mulh signs both, mulhsu only rs1, mulhu neither
    assign a_signed = (inst.r_fmt.funct3 == f3_mulh) || (inst.r_fmt.funct3 == f3_mulhsu);
    assign b_signed = (inst.r_fmt.funct3 == f3_mulh);
    assign a_ext    = {a_signed & issue_src1[31], issue_src1};
    assign b_ext    = {b_signed & issue_src2[31], issue_src2};
    assign product  = a_ext * b_ext;
    // low half is the same for any signedness
    assign result   = (inst.r_fmt.funct3 == f3_mul) ? product[31:0] : product[63:32];

    // no stall, a fixed shift of MUL_STAGES
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe[0] <= issue_valid;
            for (int i = 1; i < MUL_STAGES; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_pipe[0]  <= issue_rob_idx;
        data_pipe[0] <= result;
        for (int i = 1; i < MUL_STAGES; i++) begin
            tag_pipe[i]  <= tag_pipe[i-1];
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    assign mul_done    = valid_pipe[MUL_STAGES-1];
    assign mul_rob_idx = tag_pipe[MUL_STAGES-1];
    assign mul_result  = data_pipe[MUL_STAGES-1];

endmodule

//--- hdl/int_alu.sv
module int_alu
    import rv32i_types_pkg::*;
#(
    parameter int ROB_IDX_WIDTH = 5
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_valid,
    input  logic [31:0]              issue_inst,
    input  logic [31:0]              issue_src1,
    input  logic [31:0]              issue_src2,
    input  logic [ROB_IDX_WIDTH-1:0] issue_rob_idx,
    input  logic                     alu_grant,
    output logic                     alu_done,
    output logic [ROB_IDX_WIDTH-1:0] alu_rob_idx,
    output logic [31:0]              alu_result,
    output logic                     alu_busy
);

    inst_word_t  inst;
    logic        is_imm;
    logic        alt;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic [31:0] sra_res;
    logic [31:0] result;

    assign inst   = issue_inst;
    assign is_imm = (inst.i_fmt.opcode == op_imm);
    // i-type immediate, sign extended
    assign op_b   = is_imm ? {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12} : issue_src2;
    assign shamt  = op_b[4:0];
    // srai keeps the alt bit in imm[10], same spot as funct7
    assign alt    = (inst.r_fmt.funct7 == funct7_alt);
    // kept apart so the shift stays signed
    assign sra_res = $signed(issue_src1) >>> shamt;

    always_comb begin
        case (inst.r_fmt.funct3)
            // sub only in register form
            f3_add:  result = (alt && !is_imm) ? issue_src1 - op_b : issue_src1 + op_b;
            f3_sll:  result = issue_src1 << shamt;
            f3_slt:  result = {31'b0, $signed(issue_src1) < $signed(op_b)};
            f3_sltu: result = {31'b0, issue_src1 < op_b};
            f3_xor:  result = issue_src1 ^ op_b;
            f3_srl:  result = alt ? sra_res : issue_src1 >> shamt;
            f3_or:   result = issue_src1 | op_b;
            f3_and:  result = issue_src1 & op_b;
        endcase
    end

    // done stays up until the arbiter grants
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_done <= 1'b0;
        end else if (issue_valid) begin
            alu_done <= 1'b1;
        end else if (alu_grant) begin
            alu_done <= 1'b0;
        end
    end

    // held result, reloaded only on issue
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            alu_result  <= result;
            alu_rob_idx <= issue_rob_idx;
        end
    end

    // a grant this cycle frees the register for a back-to-back issue
    assign alu_busy = alu_done && !alu_grant;

    // a waiting result must not change under the arbiter
    a_hold: assert property (@(posedge clk) disable iff (rst)
        alu_busy |=> alu_done && $stable(alu_result) && $stable(alu_rob_idx))
        else $error("ALU result changed before grant");

endmodule

//--- hdl/reservation_station.sv
module reservation_station
    import ooo_types_pkg::*;
#(
    parameter int ROB_IDX_WIDTH = 5
) (
    input  logic                     clk,
    input  logic                     rst,
    // dispatch side
    input  logic                     dispatch_valid,
    input  logic [31:0]              dispatch_inst,
    input  logic [ROB_IDX_WIDTH-1:0] dispatch_rob_idx,
    input  logic                     rs1_ready,
    input  logic [31:0]              rs1_data,
    input  logic [ROB_IDX_WIDTH-1:0] rs1_rob_idx,
    input  logic                     rs2_ready,
    input  logic [31:0]              rs2_data,
    input  logic [ROB_IDX_WIDTH-1:0] rs2_rob_idx,
    // snooped result bus
    input  logic                     cdb_valid,
    input  logic [ROB_IDX_WIDTH-1:0] cdb_rob_idx,
    input  logic [31:0]              cdb_data,
    // issue side
    input  logic                     issue_enable,
    output logic                     available,
    output logic                     issue_valid,
    output logic [31:0]              issue_inst,
    output logic [31:0]              issue_src1,
    output logic [31:0]              issue_src2,
    output logic [ROB_IDX_WIDTH-1:0] issue_rob_idx
);

    rs_status_e               status;
    logic [31:0]              inst_q;
    logic [ROB_IDX_WIDTH-1:0] rob_idx_q;
    logic                     src1_ready;
    logic                     src2_ready;
    logic [31:0]              src1_q;
    logic [31:0]              src2_q;
    logic [ROB_IDX_WIDTH-1:0] src1_tag;
    logic [ROB_IDX_WIDTH-1:0] src2_tag;
    logic                     disp_hit1;
    logic                     disp_hit2;
    logic                     wake1;
    logic                     wake2;

    // same-cycle bypass, producer broadcasting while we dispatch
    assign disp_hit1 = cdb_valid && !rs1_ready && (cdb_rob_idx == rs1_rob_idx);
    assign disp_hit2 = cdb_valid && !rs2_ready && (cdb_rob_idx == rs2_rob_idx);

    // wakeup by rob tag, each operand on its own
    assign wake1 = cdb_valid && (status == busy) && !src1_ready && (cdb_rob_idx == src1_tag);
    assign wake2 = cdb_valid && (status == busy) && !src2_ready && (cdb_rob_idx == src2_tag);

    always_ff @(posedge clk) begin
        if (rst) begin
            status     <= idle;
            src1_ready <= 1'b0;
            src2_ready <= 1'b0;
        end else if (dispatch_valid) begin
            status     <= busy;
            src1_ready <= rs1_ready || disp_hit1;
            src2_ready <= rs2_ready || disp_hit2;
        end else begin
            // slot frees at the issue edge
            if (issue_valid) begin
                status <= idle;
            end
            if (wake1) begin
                src1_ready <= 1'b1;
            end
            if (wake2) begin
                src2_ready <= 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            inst_q    <= dispatch_inst;
            rob_idx_q <= dispatch_rob_idx;
            src1_tag  <= rs1_rob_idx;
            src2_tag  <= rs2_rob_idx;
            // bus value only matters on a bypass hit
            src1_q    <= rs1_ready ? rs1_data : cdb_data;
            src2_q    <= rs2_ready ? rs2_data : cdb_data;
        end else begin
            if (wake1) begin
                src1_q <= cdb_data;
            end
            if (wake2) begin
                src2_q <= cdb_data;
            end
        end
    end

    assign available     = (status != busy);
    // unit may hold us off via issue_enable
    assign issue_valid   = (status == busy) && src1_ready && src2_ready && issue_enable;
    assign issue_inst    = inst_q;
    assign issue_src1    = src1_q;
    assign issue_src2    = src2_q;
    assign issue_rob_idx = rob_idx_q;

    // dispatcher has to honor the available flag
    a_no_dispatch_busy: assert property (@(posedge clk) disable iff (rst)
        dispatch_valid |-> (status != busy))
        else $error("dispatch into a busy reservation station");

    // a held entry has not executed yet, so its tag cannot be on the bus
    a_own_tag: assert property (@(posedge clk) disable iff (rst)
        (status == busy) && cdb_valid |-> (cdb_rob_idx != rob_idx_q))
        else $error("CDB broadcast of a tag still held in the reservation station");

endmodule

//--- hdl/ooo_types_pkg.sv
package ooo_types_pkg;

    // state of a one-entry station
    typedef enum logic [1:0] {
        idle   = 2'b00,
        busy   = 2'b01,
        issued = 2'b10
    } rs_status_e;

    // dispatch target
    typedef enum logic {
        unit_alu = 1'b0,
        unit_mul = 1'b1
    } exec_unit_e;

endpackage

//--- hdl/rv32i_types_pkg.sv
package rv32i_types_pkg;

    // major opcodes of the integer arithmetic groups
    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011
    } opcode_e;

    // one instruction word, read as r-type or as i-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            opcode_e    opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            opcode_e     opcode;
        } i_fmt;
    } inst_word_t;

    // alu funct3
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // m extension multiply funct3
    localparam logic [2:0] f3_mul    = 3'b000;
    localparam logic [2:0] f3_mulh   = 3'b001;
    localparam logic [2:0] f3_mulhsu = 3'b010;
    localparam logic [2:0] f3_mulhu  = 3'b011;

    // sub / sra select, and the muldiv group
    localparam logic [6:0] funct7_alt    = 7'b0100000;
    localparam logic [6:0] funct7_muldiv = 7'b0000001;

endpackage
